// File: rtl/axi_apb_defines.svh
`ifndef AXI_APB_DEFINES_SVH
`define AXI_APB_DEFINES_SVH

// bus widths.
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W   12
`define AXI_LEN_W  8

// response codes shared by B and R.
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// File: rtl/axi_pkg.sv
`default_nettype none

`include "axi_apb_defines.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_W-1:0]     addr_t;
    typedef logic [`AXI_DATA_W-1:0]     data_t;
    typedef logic [`AXI_DATA_W/8-1:0]   strb_t;
    typedef logic [`AXI_ID_W-1:0]       id_t;

    // number of beats minus one.
    typedef logic [`AXI_LEN_W-1:0]      len_t;

    // log2 of bytes per beat.
    typedef logic [2:0]                 size_t;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef logic [1:0]                 resp_t;

endpackage

`default_nettype wire

// File: rtl/apb_pkg.sv
`default_nettype none

`include "axi_apb_defines.svh"

package apb_pkg;

    typedef logic [`AXI_DATA_W-1:0]   pdata_t;
    typedef logic [`AXI_DATA_W/8-1:0] pstrb_t;

    // one APB transfer per beat.
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        WAIT_RSP
    } exec_state_e;

endpackage

`default_nettype wire

// File: rtl/bridge_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

interface bridge_cmd_if;

    logic                   cmd_valid;
    logic                   cmd_write;
    logic [`AXI_ADDR_W-1:0] cmd_addr;
    logic                   cmd_last;
    // beat handed on to result.
    logic                   cmd_adv;

    modport decode (
        output cmd_valid,
        output cmd_write,
        output cmd_addr,
        output cmd_last,
        input  cmd_adv
    );

    modport execute (
        input  cmd_valid,
        input  cmd_write,
        input  cmd_addr,
        input  cmd_last,
        output cmd_adv
    );

endinterface

`default_nettype wire

// File: rtl/bridge_rsp_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

interface bridge_rsp_if;

    logic                   rsp_valid;
    logic                   rsp_ready;
    logic                   rsp_write;
    logic                   rsp_last;
    logic [`AXI_DATA_W-1:0] rsp_data;
    logic                   rsp_err;

    modport execute (
        output rsp_valid,
        input  rsp_ready,
        output rsp_write,
        output rsp_last,
        output rsp_data,
        output rsp_err
    );

    modport result (
        input  rsp_valid,
        output rsp_ready,
        input  rsp_write,
        input  rsp_last,
        input  rsp_data,
        input  rsp_err
    );

endinterface

`default_nettype wire

// File: rtl/axi_req_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

module axi_req_decode (
    input  wire                  aclk,
    input  wire                  aresetn,
    input  wire axi_pkg::addr_t  awaddr,
    input  wire axi_pkg::id_t    awid,
    input  wire axi_pkg::len_t   awlen,
    input  wire axi_pkg::size_t  awsize,
    input  wire axi_pkg::burst_e awburst,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire axi_pkg::addr_t  araddr,
    input  wire axi_pkg::id_t    arid,
    input  wire axi_pkg::len_t   arlen,
    input  wire axi_pkg::size_t  arsize,
    input  wire axi_pkg::burst_e arburst,
    input  wire                  arvalid,
    output logic                 arready,
    output axi_pkg::id_t         rsp_id,
    bridge_cmd_if.decode         cmd
);

    import axi_pkg::*;

    logic   idle_q;
    logic   busy_q;
    logic   write_q;
    logic   ar_hs;
    logic   aw_hs;
    addr_t  sel_addr;
    id_t    sel_id;
    len_t   sel_len;
    size_t  sel_size;
    burst_e sel_burst;
    addr_t  addr_q;
    addr_t  mask_q;
    addr_t  addr_step;
    id_t    id_q;
    len_t   cnt_q;
    size_t  size_q;

    // set bits of the mask are kept across beats.
    function automatic addr_t burst_mask(burst_e burst, len_t len, size_t size);
        addr_t span;
        span = (addr_t'(len) + addr_t'(1)) << size;
        case (burst)
            FIXED:   return '1;
            WRAP:    return ~(span - addr_t'(1));
            default: return '0;
        endcase
    endfunction

    // reads win a same-cycle tie.
    assign arready = idle_q;
    assign awready = idle_q & ~arvalid;
    assign ar_hs   = arvalid & arready;
    assign aw_hs   = awvalid & awready;

    assign sel_addr  = ar_hs ? araddr  : awaddr;
    assign sel_id    = ar_hs ? arid    : awid;
    assign sel_len   = ar_hs ? arlen   : awlen;
    assign sel_size  = ar_hs ? arsize  : awsize;
    assign sel_burst = ar_hs ? arburst : awburst;

    assign addr_step = addr_q + (addr_t'(1) << size_q);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            idle_q  <= 1'b0;
            busy_q  <= 1'b0;
            write_q <= 1'b0;
            cnt_q   <= '0;
        end
        else if (ar_hs || aw_hs) begin
            idle_q  <= 1'b0;
            busy_q  <= 1'b1;
            write_q <= aw_hs;
            cnt_q   <= sel_len;
        end
        else if (cmd.cmd_adv) begin
            cnt_q <= cnt_q - len_t'(1);
            if (cmd.cmd_last) begin
                idle_q <= 1'b1;
                busy_q <= 1'b0;
            end
        end
        else if (!busy_q) begin
            idle_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs || aw_hs) begin
            id_q   <= sel_id;
            size_q <= sel_size;
            addr_q <= sel_addr;
            mask_q <= burst_mask(sel_burst, sel_len, sel_size);
        end
        else if (cmd.cmd_adv) begin
            addr_q <= (addr_q & mask_q) | (addr_step & ~mask_q);
        end
    end

    assign cmd.cmd_valid = busy_q;
    assign cmd.cmd_write = write_q;
    assign cmd.cmd_addr  = addr_q;
    assign cmd.cmd_last  = (cnt_q == '0);
    assign rsp_id        = id_q;

endmodule

`default_nettype wire

// File: rtl/apb_xfer_exec.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

module apb_xfer_exec (
    input  wire                  aclk,
    input  wire                  aresetn,
    bridge_cmd_if.execute        cmd,
    bridge_rsp_if.execute        rsp,
    input  wire apb_pkg::pdata_t wdata,
    input  wire apb_pkg::pstrb_t wstrb,
    input  wire                  wvalid,
    output logic                 wready,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output axi_pkg::addr_t       paddr,
    output apb_pkg::pdata_t      pwdata,
    output apb_pkg::pstrb_t      pstrb,
    input  wire apb_pkg::pdata_t prdata,
    input  wire                  pready,
    input  wire                  pslverr
);

    import axi_pkg::*;
    import apb_pkg::*;

    exec_state_e state_q;
    exec_state_e state_d;
    logic        done;
    data_t       rdata_q;
    logic        err_q;

    assign done = (state_q == ACCESS) && pready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // a write beat needs its W data first.
                if (cmd.cmd_valid && (!cmd.cmd_write || wvalid)) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                state_d = ACCESS;
            end
            ACCESS: begin
                if (pready) begin
                    state_d = WAIT_RSP;
                end
            end
            WAIT_RSP: begin
                if (rsp.rsp_ready) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= IDLE;
        end
        else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (done) begin
            rdata_q <= prdata;
            err_q   <= pslverr;
        end
    end

    assign psel    = (state_q == SETUP) || (state_q == ACCESS);
    assign penable = (state_q == ACCESS);
    assign pwrite  = cmd.cmd_write;
    assign paddr   = cmd.cmd_addr;
    assign pwdata  = wdata;
    assign pstrb   = cmd.cmd_write ? wstrb : '0;

    // W beat consumed on APB completion.
    assign wready = done && cmd.cmd_write;

    assign rsp.rsp_valid = (state_q == WAIT_RSP);
    assign rsp.rsp_write = cmd.cmd_write;
    assign rsp.rsp_last  = cmd.cmd_last;
    assign rsp.rsp_data  = rdata_q;
    assign rsp.rsp_err   = err_q;

    assign cmd.cmd_adv = rsp.rsp_valid && rsp.rsp_ready;

endmodule

`default_nettype wire

// File: rtl/axi_resp_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

module axi_resp_gen (
    input  wire                 aclk,
    input  wire                 aresetn,
    bridge_rsp_if.result        rsp,
    input  wire axi_pkg::id_t   rsp_id,
    output axi_pkg::id_t        bid,
    output axi_pkg::resp_t      bresp,
    output logic                bvalid,
    input  wire                 bready,
    output axi_pkg::id_t        rid,
    output axi_pkg::data_t      rdata,
    output axi_pkg::resp_t      rresp,
    output logic                rlast,
    output logic                rvalid,
    input  wire                 rready
);

    import axi_pkg::*;

    logic take;
    logic rd_take;
    logic wr_take;
    logic err_sticky_q;

    function automatic resp_t to_resp(logic err);
        return err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    endfunction

    // a pending R or B stalls the beat.
    assign rsp.rsp_ready = rsp.rsp_write ? !bvalid : !rvalid;

    assign take    = rsp.rsp_valid && rsp.rsp_ready;
    assign rd_take = take && !rsp.rsp_write;
    assign wr_take = take && rsp.rsp_write;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rvalid       <= 1'b0;
            bvalid       <= 1'b0;
            err_sticky_q <= 1'b0;
        end
        else begin
            if (rd_take) begin
                rvalid <= 1'b1;
            end
            else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_take && rsp.rsp_last) begin
                bvalid <= 1'b1;
            end
            else if (bready) begin
                bvalid <= 1'b0;
            end

            // error of any write beat sticks until B goes out.
            if (bvalid && bready) begin
                err_sticky_q <= 1'b0;
            end
            else if (wr_take && rsp.rsp_err) begin
                err_sticky_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_take) begin
            rid   <= rsp_id;
            rdata <= rsp.rsp_data;
            rresp <= to_resp(rsp.rsp_err);
            rlast <= rsp.rsp_last;
        end
        if (wr_take && rsp.rsp_last) begin
            bid <= rsp_id;
        end
    end

    assign bresp = to_resp(err_sticky_q);

endmodule

`default_nettype wire

// File: rtl/axi2apb_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

module axi2apb_bridge (
    input  wire                  aclk,
    input  wire                  aresetn,
    input  wire axi_pkg::burst_e s_awburst,
    input  wire axi_pkg::id_t    s_awid,
    input  wire axi_pkg::addr_t  s_awaddr,
    input  wire axi_pkg::size_t  s_awsize,
    input  wire axi_pkg::len_t   s_awlen,
    input  wire                  s_awvalid,
    output logic                 s_awready,
    input  wire axi_pkg::strb_t  s_wstrb,
    input  wire axi_pkg::data_t  s_wdata,
    input  wire                  s_wvalid,
    output logic                 s_wready,
    output axi_pkg::id_t         s_bid,
    output axi_pkg::resp_t       s_bresp,
    output logic                 s_bvalid,
    input  wire                  s_bready,
    input  wire axi_pkg::addr_t  s_araddr,
    input  wire axi_pkg::burst_e s_arburst,
    input  wire axi_pkg::size_t  s_arsize,
    input  wire axi_pkg::id_t    s_arid,
    input  wire axi_pkg::len_t   s_arlen,
    input  wire                  s_arvalid,
    output logic                 s_arready,
    output axi_pkg::data_t       s_rdata,
    output axi_pkg::resp_t       s_rresp,
    output axi_pkg::id_t         s_rid,
    output logic                 s_rlast,
    output logic                 s_rvalid,
    input  wire                  s_rready,
    output logic                 psel,
    output logic                 penable,
    output axi_pkg::addr_t       paddr,
    output logic                 pwrite,
    output apb_pkg::pstrb_t      pstrb,
    output apb_pkg::pdata_t      pwdata,
    input  wire apb_pkg::pdata_t prdata,
    input  wire                  pslverr,
    input  wire                  pready
);

    axi_pkg::id_t burst_id;

    bridge_cmd_if cmd_bus ();
    bridge_rsp_if rsp_bus ();

    axi_req_decode u_decode (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awaddr  (s_awaddr),
        .awid    (s_awid),
        .awlen   (s_awlen),
        .awsize  (s_awsize),
        .awburst (s_awburst),
        .awvalid (s_awvalid),
        .awready (s_awready),
        .araddr  (s_araddr),
        .arid    (s_arid),
        .arlen   (s_arlen),
        .arsize  (s_arsize),
        .arburst (s_arburst),
        .arvalid (s_arvalid),
        .arready (s_arready),
        .rsp_id  (burst_id),
        .cmd     (cmd_bus.decode)
    );

    apb_xfer_exec u_exec (
        .aclk    (aclk),
        .aresetn (aresetn),
        .cmd     (cmd_bus.execute),
        .rsp     (rsp_bus.execute),
        .wdata   (s_wdata),
        .wstrb   (s_wstrb),
        .wvalid  (s_wvalid),
        .wready  (s_wready),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    axi_resp_gen u_resp (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rsp     (rsp_bus.result),
        .rsp_id  (burst_id),
        .bid     (s_bid),
        .bresp   (s_bresp),
        .bvalid  (s_bvalid),
        .bready  (s_bready),
        .rid     (s_rid),
        .rdata   (s_rdata),
        .rresp   (s_rresp),
        .rlast   (s_rlast),
        .rvalid  (s_rvalid),
        .rready  (s_rready)
    );

endmodule

`default_nettype wire

// File: dv/apb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

module apb_mem_model (
    input  wire                  aclk,
    input  wire                  aresetn,
    input  wire                  psel,
    input  wire                  penable,
    input  wire                  pwrite,
    input  wire axi_pkg::addr_t  paddr,
    input  wire apb_pkg::pdata_t pwdata,
    input  wire apb_pkg::pstrb_t pstrb,
    output apb_pkg::pdata_t      prdata,
    output logic                 pready,
    output logic                 pslverr
);

    import apb_pkg::*;

    pdata_t      mem [0:255];
    logic [1:0]  wait_q;
    logic [31:0] rnd_q;
    logic        in_window;
    logic [7:0]  idx;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5EED0000 ^ (i << 2);
        end
    end

    assign idx       = paddr[9:2];
    assign in_window = (paddr[11:8] == 4'hF);
    assign pready    = psel && penable && (wait_q == 2'd0);
    assign pslverr   = pready && in_window;
    assign prdata    = (psel && !in_window) ? mem[idx] : '0;

    // wait states are drawn in the setup phase.
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wait_q <= 2'd0;
            rnd_q  <= 32'd91;
        end
        else if (psel && !penable) begin
            wait_q <= rnd_q[1:0];
            rnd_q  <= xorshift32(rnd_q);
        end
        else if (psel && penable && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    always @(posedge aclk) begin
        if (pready && pwrite && !in_window) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_axi2apb_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_apb_defines.svh"

module tb_axi2apb_bridge;

    import axi_pkg::*;
    import apb_pkg::*;

    localparam int TIMEOUT = 300;

    logic   aclk;
    logic   aresetn;
    burst_e s_awburst;
    id_t    s_awid;
    addr_t  s_awaddr;
    size_t  s_awsize;
    len_t   s_awlen;
    logic   s_awvalid;
    logic   s_awready;
    strb_t  s_wstrb;
    data_t  s_wdata;
    logic   s_wvalid;
    logic   s_wready;
    id_t    s_bid;
    resp_t  s_bresp;
    logic   s_bvalid;
    logic   s_bready;
    addr_t  s_araddr;
    burst_e s_arburst;
    size_t  s_arsize;
    id_t    s_arid;
    len_t   s_arlen;
    logic   s_arvalid;
    logic   s_arready;
    data_t  s_rdata;
    resp_t  s_rresp;
    id_t    s_rid;
    logic   s_rlast;
    logic   s_rvalid;
    logic   s_rready;
    logic   psel;
    logic   penable;
    addr_t  paddr;
    logic   pwrite;
    pstrb_t pstrb;
    pdata_t pwdata;
    pdata_t prdata;
    logic   pslverr;
    logic   pready;

    data_t       ref_mem [0:255];
    addr_t       exp_paddr[$];
    logic [31:0] rnd_state;
    logic        bp_on;
    int          rd_held;
    int          errors;
    int          n_pass;
    int          n_fail;

    axi2apb_bridge UUT (.*);

    apb_mem_model u_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // low about half the time under back-pressure.
    function automatic logic ready_bit();
        logic [31:0] r;
        r = next_rand();
        return bp_on ? r[4] : 1'b1;
    endfunction

    function automatic logic in_err_window(addr_t a);
        return a[11:8] == 4'hF;
    endfunction

    // wrap keeps the beat inside its aligned (len+1) * 2^size window.
    function automatic addr_t next_addr(addr_t a, burst_e burst, len_t len, size_t size);
        addr_t step;
        addr_t span;
        addr_t base;
        step = addr_t'(1) << size;
        span = (addr_t'(len) + addr_t'(1)) * step;
        base = (a / span) * span;
        case (burst)
            FIXED:   return a;
            WRAP:    return base + ((a - base + step) % span);
            default: return a + step;
        endcase
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        assert (exp_paddr.size() == 0)
            else report_error($sformatf("%0d APB transfers missing", exp_paddr.size()));
        if (errors == errs_before) begin
            n_pass++;
            $display("test %s: pass", name);
        end
        else begin
            n_fail++;
            $display("test %s: fail", name);
        end
    endtask

    task automatic predict_apb(input addr_t addr, input len_t len, input size_t size,
                               input burst_e burst);
        addr_t a;
        a = addr;
        for (int beat = 0; beat <= len; beat++) begin
            exp_paddr.push_back(a);
            a = next_addr(a, burst, len, size);
        end
    endtask

    task automatic present_ar(input id_t id, input addr_t addr, input len_t len,
                              input size_t size, input burst_e burst);
        s_arid    <= id;
        s_araddr  <= addr;
        s_arlen   <= len;
        s_arsize  <= size;
        s_arburst <= burst;
        s_arvalid <= 1'b1;
    endtask

    task automatic present_aw(input id_t id, input addr_t addr, input len_t len,
                              input size_t size, input burst_e burst);
        s_awid    <= id;
        s_awaddr  <= addr;
        s_awlen   <= len;
        s_awsize  <= size;
        s_awburst <= burst;
        s_awvalid <= 1'b1;
    endtask

    task automatic wait_ar_accept();
        int t;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) abort_run("AR handshake");
        end while (!s_arready);
        s_arvalid <= 1'b0;
    endtask

    task automatic wait_aw_accept();
        int t;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) abort_run("AW handshake");
        end while (!s_awready);
        s_awvalid <= 1'b0;
    endtask

    task automatic recv_read(input id_t id, input addr_t addr, input len_t len,
                             input size_t size, input burst_e burst);
        addr_t a;
        int    t;
        logic  got;
        resp_t exp_resp;
        a = addr;
        for (int beat = 0; beat <= len; beat++) begin
            s_rready <= ready_bit();
            t = 0;
            do begin
                @(posedge aclk);
                t++;
                if (t > TIMEOUT) abort_run("R beat");
                got = s_rvalid && s_rready;
                if (!got) s_rready <= ready_bit();
            end while (!got);
            exp_resp = in_err_window(a) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
            assert (s_rid == id)
                else report_error($sformatf("rid %0h, expected %0h", s_rid, id));
            assert (s_rlast == (beat == len))
                else report_error($sformatf("rlast %0b on beat %0d", s_rlast, beat));
            assert (s_rresp == exp_resp)
                else report_error($sformatf("rresp %0d at %0h", s_rresp, a));
            if (!in_err_window(a)) begin
                assert (s_rdata == ref_mem[a[9:2]])
                    else report_error($sformatf("rdata %0h at %0h, expected %0h",
                                                s_rdata, a, ref_mem[a[9:2]]));
            end
            a = next_addr(a, burst, len, size);
        end
        s_rready <= 1'b0;
    endtask

    task automatic send_wbeats(input addr_t addr, input len_t len, input size_t size,
                               input burst_e burst, input strb_t strb);
        addr_t a;
        data_t d;
        int    t;
        a = addr;
        for (int beat = 0; beat <= len; beat++) begin
            d = next_rand();
            s_wdata  <= d;
            s_wstrb  <= strb;
            s_wvalid <= 1'b1;
            t = 0;
            do begin
                @(posedge aclk);
                t++;
                if (t > TIMEOUT) abort_run("W handshake");
            end while (!s_wready);
            if (!in_err_window(a)) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) ref_mem[a[9:2]][8*b +: 8] = d[8*b +: 8];
                end
            end
            a = next_addr(a, burst, len, size);
        end
        s_wvalid <= 1'b0;
    endtask

    task automatic recv_b(input id_t id, input logic exp_err);
        int   t;
        logic got;
        s_bready <= ready_bit();
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) abort_run("B response");
            got = s_bvalid && s_bready;
            if (!got) s_bready <= ready_bit();
        end while (!got);
        s_bready <= 1'b0;
        assert (s_bid == id)
            else report_error($sformatf("bid %0h, expected %0h", s_bid, id));
        assert (s_bresp == (exp_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY))
            else report_error($sformatf("bresp %0d, expected error %0b", s_bresp, exp_err));
    endtask

    task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                               input size_t size, input burst_e burst, input strb_t strb);
        addr_t a;
        logic  any_err;
        a = addr;
        any_err = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            any_err = any_err | in_err_window(a);
            a = next_addr(a, burst, len, size);
        end
        predict_apb(addr, len, size, burst);
        present_aw(id, addr, len, size, burst);
        wait_aw_accept();
        send_wbeats(addr, len, size, burst, strb);
        recv_b(id, any_err);
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                              input size_t size, input burst_e burst);
        predict_apb(addr, len, size, burst);
        present_ar(id, addr, len, size, burst);
        wait_ar_accept();
        recv_read(id, addr, len, size, burst);
    endtask

    // every completed APB transfer must match the predicted beat address.
    always @(posedge aclk) begin
        if (aresetn && psel && penable && pready) begin
            if (exp_paddr.size() == 0) begin
                report_error($sformatf("unexpected APB transfer at %0h", paddr));
            end
            else begin
                assert (paddr == exp_paddr[0])
                    else report_error($sformatf("paddr %0h, expected %0h",
                                                paddr, exp_paddr[0]));
                void'(exp_paddr.pop_front());
            end
        end
    end

    // read beats done on APB but not yet taken on R.
    always @(posedge aclk) begin
        if (!aresetn) begin
            rd_held = 0;
        end
        else begin
            if (psel && !penable) begin
                assert (rd_held <= 1)
                    else report_error("new APB transfer while two read beats wait on R");
            end
            if (psel && penable && pready && !pwrite) begin
                rd_held++;
            end
            if (s_rvalid && s_rready) begin
                rd_held--;
            end
        end
    end

    penable_after_setup: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(penable) |-> psel && $past(psel) && !$past(penable))
        else report_error("penable rose without a setup phase");

    apb_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        psel && !(penable && pready) |=>
            $stable(paddr) && $stable(pwrite) && (!pwrite || $stable(pwdata)))
        else report_error("APB address or data changed before pready");

    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rlast))
        else report_error("R beat changed before acceptance");

    b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp) && $stable(s_bid))
        else report_error("B response changed before acceptance");

    initial begin
        int errs;
        int t;
        rnd_state = 32'd91;
        bp_on     = 1'b0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 32'h5EED0000 ^ (i << 2);
        end
        aresetn   = 1'b0;
        s_awburst = INCR;
        s_awid    = '0;
        s_awaddr  = '0;
        s_awsize  = '0;
        s_awlen   = '0;
        s_awvalid = 1'b0;
        s_wstrb   = '0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arburst = INCR;
        s_arsize  = '0;
        s_arid    = '0;
        s_arlen   = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;

        errs = errors;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        assert (!psel && !penable && !s_bvalid && !s_rvalid)
            else report_error("outputs not idle after reset");
        finish_test("reset", errs);

        errs = errors;
        write_burst(12'h011, 32'h40, 8'd3, 3'd2, INCR, 4'hF);
        write_burst(12'h012, 32'h44, 8'd0, 3'd2, INCR, 4'b0110);
        read_burst(12'h013, 32'h40, 8'd3, 3'd2, INCR);
        finish_test("incr", errs);

        errs = errors;
        write_burst(12'h021, 32'h108, 8'd3, 3'd2, WRAP, 4'hF);
        read_burst(12'h022, 32'h108, 8'd3, 3'd2, WRAP);
        read_burst(12'h023, 32'h104, 8'd3, 3'd2, WRAP);
        write_burst(12'h024, 32'h200, 8'd2, 3'd2, FIXED, 4'b0011);
        read_burst(12'h025, 32'h200, 8'd2, 3'd2, FIXED);
        finish_test("wrap_fixed", errs);

        errs = errors;
        write_burst(12'h031, 32'hEF4, 8'd3, 3'd2, INCR, 4'hF);
        read_burst(12'h032, 32'hEF8, 8'd3, 3'd2, INCR);
        finish_test("errors", errs);

        errs = errors;
        bp_on = 1'b1;
        read_burst(12'h041, 32'h300, 8'd7, 3'd2, INCR);
        write_burst(12'h042, 32'h380, 8'd3, 3'd2, INCR, 4'hF);
        read_burst(12'h043, 32'h380, 8'd3, 3'd2, INCR);
        bp_on = 1'b0;
        finish_test("backpressure", errs);

        // read and write raised together; the read goes first.
        errs = errors;
        predict_apb(32'h60, 8'd1, 3'd2, INCR);
        predict_apb(32'h60, 8'd1, 3'd2, INCR);
        present_ar(12'h051, 32'h60, 8'd1, 3'd2, INCR);
        present_aw(12'h052, 32'h60, 8'd1, 3'd2, INCR);
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) abort_run("AR handshake");
        end while (!s_arready);
        assert (!s_awready)
            else report_error("awready high in the cycle the read was taken");
        s_arvalid <= 1'b0;
        // the write is taken as soon as the read burst ends.
        fork
            recv_read(12'h051, 32'h60, 8'd1, 3'd2, INCR);
            wait_aw_accept();
        join
        send_wbeats(32'h60, 8'd1, 3'd2, INCR, 4'hF);
        recv_b(12'h052, 1'b0);
        read_burst(12'h053, 32'h60, 8'd1, 3'd2, INCR);
        finish_test("arbitration", errs);

        repeat (4) @(posedge aclk);
        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/apb_pkg.sv
rtl/bridge_cmd_if.sv
rtl/bridge_rsp_if.sv
rtl/axi_req_decode.sv
rtl/apb_xfer_exec.sv
rtl/axi_resp_gen.sv
rtl/axi2apb_bridge.sv
dv/apb_mem_model.sv
dv/tb_axi2apb_bridge.sv
